// ==== Makefile ====
TOP := alu_issue_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): alu_issue.f *.sv *.svh
	verilator --binary --assert --timing -Wno-fatal --top-module $(TOP) -f alu_issue.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f alu_issue.f

clean:
	rm -rf obj_dir sim.log

// ==== alu_exec.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_exec (
    input  wire  alu_op_pkg::alu_op_e   op_i,
    input  wire  core_types_pkg::word_t a_i,
    input  wire  core_types_pkg::word_t b_i,
    output core_types_pkg::word_t       result_o
);
    import alu_op_pkg::*;

    logic [4:0] shamt;

    // shift amount from the low bits of b
    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            OP_ADD:  result_o = a_i + b_i;
            OP_SUB:  result_o = a_i - b_i;
            OP_AND:  result_o = a_i & b_i;
            OP_OR:   result_o = a_i | b_i;
            OP_XOR:  result_o = a_i ^ b_i;
            OP_SLL:  result_o = a_i << shamt;
            OP_SRL:  result_o = a_i >> shamt;
            OP_SRA:  result_o = $signed(a_i) >>> shamt;
            // comparisons give 0 or 1
            OP_SLT: begin
                result_o = '0;
                result_o[0] = $signed(a_i) < $signed(b_i);
            end
            OP_SLTU: begin
                result_o = '0;
                result_o[0] = a_i < b_i;
            end
            OP_LUI:  result_o = b_i;
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== alu_iq.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "alu_issue_defines.svh"

module alu_iq (
    input  wire                                            clk,
    input  wire                                            rst_i,
    input  wire                                            flush_i,
    input  wire  alu_op_pkg::alu_inst_t                    disp_i,
    input  wire                                            disp_valid_i,
    output logic                                           iq_ready_o,
    input  wire  core_types_pkg::cdb_beat_t [`CDB_CNT-1:0] cdb_i,
    input  wire                                            fifo_ready_i,
    output core_types_pkg::alu_result_t                    res_o,
    output logic                                           res_valid_o
);
    import core_types_pkg::*;
    import alu_op_pkg::*;

    localparam int CNT_W = $clog2(`IQ_SIZE) + 1;
    localparam int IDX_W = $clog2(`IQ_SIZE);

    logic [`IQ_SIZE-1:0]                 entry_ready;
    logic [`IQ_SIZE-1:0]                 entry_select;
    logic [`IQ_SIZE-1:0]                 entry_init;
    logic [`IQ_SIZE-1:0]                 entry_busy_q;
    alu_inst_t [`IQ_SIZE-1:0]            entry_inst;
    logic [`IQ_SIZE-1:0][`AGING_LEN-1:0] age_q;
    logic [IDX_W-1:0]                    sel_idx;
    logic                                sel_any;
    logic [CNT_W-1:0]                    free_cnt_q;
    logic [CNT_W-1:0]                    free_nxt;
    logic                                disp_fire;
    logic                                issue_fire;
    logic                                advance;
    logic                                ex_valid_q;
    alu_inst_t                           ex_inst_q;
    word_t                               ex_result;
    logic                                res_valid_q;
    alu_result_t                         res_q;

    assign disp_fire  = disp_valid_i && iq_ready_o;
    // pipeline moves when the result register can hand off
    assign advance    = !res_valid_q || fifo_ready_i;
    assign issue_fire = advance && sel_any;

    // ----------------------------------------
    // age based select
    // ----------------------------------------
    // larger one-hot age is older, ties go to the lower index
    always_comb begin
        sel_idx = '0;
        sel_any = 1'b0;
        for (int i = 0; i < `IQ_SIZE; i++) begin
            if (entry_ready[i] && (!sel_any || (age_q[i] > age_q[sel_idx]))) begin
                sel_idx = IDX_W'(i);
                sel_any = 1'b1;
            end
        end
        entry_select = '0;
        entry_select[sel_idx] = issue_fire;
    end

    // new entries start young, issued ones clear
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            age_q <= '0;
        end else begin
            for (int i = 0; i < `IQ_SIZE; i++) begin
                if (entry_select[i] || entry_init[i]) begin
                    age_q[i] <= '0;
                end else if (age_q[i] == '0) begin
                    age_q[i] <= `AGING_LEN'(1);
                end else if (!age_q[i][`AGING_LEN-1]) begin
                    age_q[i] <= age_q[i] << 1;
                end
            end
        end
    end

    // ----------------------------------------
    // dispatch slot and free count
    // ----------------------------------------
    always_comb begin
        entry_init = '0;
        for (int i = 0; i < `IQ_SIZE; i++) begin
            if (!entry_busy_q[i] && (entry_init == '0)) begin
                entry_init[i] = disp_fire;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            entry_busy_q <= '0;
        end else begin
            entry_busy_q <= (entry_busy_q & ~entry_select) | entry_init;
        end
    end

    assign free_nxt = free_cnt_q - CNT_W'(disp_fire) + CNT_W'(issue_fire);

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            free_cnt_q <= CNT_W'(`IQ_SIZE);
            iq_ready_o <= 1'b1;
        end else begin
            free_cnt_q <= free_nxt;
            iq_ready_o <= (free_nxt != '0);
        end
    end

    for (genvar i = 0; i < `IQ_SIZE; i++) begin : gen_entry
        iq_entry u_entry (
            .clk      (clk),
            .rst_i    (rst_i),
            .flush_i  (flush_i),
            .init_i   (entry_init[i]),
            .inst_i   (disp_i),
            .cdb_i    (cdb_i),
            .select_i (entry_select[i]),
            .ready_o  (entry_ready[i]),
            .inst_o   (entry_inst[i])
        );
    end

    // ----------------------------------------
    // two stage execute
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            ex_valid_q  <= 1'b0;
            res_valid_q <= 1'b0;
        end else if (advance) begin
            ex_valid_q  <= issue_fire;
            res_valid_q <= ex_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            ex_inst_q    <= entry_inst[sel_idx];
            res_q.rob_id <= ex_inst_q.rob_id;
            res_q.w_reg  <= ex_inst_q.w_reg;
            res_q.w_data <= ex_result;
        end
    end

    alu_exec u_exec (
        .op_i     (ex_inst_q.op),
        .a_i      (ex_inst_q.src_data[0]),
        .b_i      (ex_inst_q.src_data[1]),
        .result_o (ex_result)
    );

    assign res_o       = res_q;
    assign res_valid_o = res_valid_q;

    a_free_bound : assert property (
        @(posedge clk) disable iff (rst_i)
        free_cnt_q <= CNT_W'(`IQ_SIZE)
    );

    // dispatch must respect the registered not-full level
    a_no_disp_full : assert property (
        @(posedge clk) disable iff (rst_i || flush_i)
        !(disp_valid_i && !iq_ready_o)
    );

endmodule

`default_nettype wire

// ==== alu_issue.f ====
+incdir+.
core_types_pkg.sv
alu_op_pkg.sv
iq_entry.sv
alu_exec.sv
alu_iq.sv
result_fifo.sv
alu_issue_top.sv
alu_issue_tb.sv

// ==== alu_issue_defines.svh ====
`ifndef ALU_ISSUE_DEFINES_SVH
`define ALU_ISSUE_DEFINES_SVH

// datapath widths
`define ALU_XLEN 32
`define ROB_ID_W 6

// ----------------------------------------
// issue queue sizing
// ----------------------------------------
`define IQ_SIZE 4

// one-hot age, saturates at the msb
`define AGING_LEN 4

// result broadcast ports
`define CDB_CNT 2

`define RES_FIFO_DEPTH 4

`endif

// ==== alu_issue_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "alu_issue_defines.svh"

module alu_issue_tb;
    import core_types_pkg::*;
    import alu_op_pkg::*;

    localparam int NTAG        = 2 ** `ROB_ID_W;
    localparam int N_RAND      = 200;
    localparam int N_INST      = N_RAND + 40;
    localparam int TIMEOUT_CYC = N_INST * 40 + 200;

    logic                     clk;
    logic                     rst_i;
    logic                     flush_i;
    alu_inst_t                disp_i;
    logic                     disp_valid_i;
    logic                     iq_ready_o;
    cdb_beat_t [`CDB_CNT-1:0] cdb_i;
    alu_result_t              res_o;
    logic                     res_valid_o;
    logic                     res_ready_i;

    integer seed = 32'h15ff_98f0;
    int     cycle_cnt;
    int     n_sent;
    int     n_outstanding;
    int     next_rob;
    int     next_wake;
    int     wake_q[$];

    // model table by rob tag
    alu_op_e m_op[NTAG];
    logic    m_wreg[NTAG];
    word_t   m_src[NTAG][2];
    logic    m_known[NTAG][2];
    logic    m_pending[NTAG];
    // wake tags still to be broadcast, and whose source each one feeds
    logic    tag_busy[NTAG];
    int      wake_rob[NTAG];
    int      wake_src[NTAG];

    alu_issue_top dut0 (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .disp_i       (disp_i),
        .disp_valid_i (disp_valid_i),
        .iq_ready_o   (iq_ready_o),
        .cdb_i        (cdb_i),
        .res_o        (res_o),
        .res_valid_o  (res_valid_o),
        .res_ready_i  (res_ready_i)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            report_failure("timeout with instructions still outstanding");
        end
    end

    // ----------------------------------------
    // error reporting and reference
    // ----------------------------------------
    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("ERR %s expected %08h actual %08h", name, exp, act);
        $display("Simulation FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "stopping at first error");
    endtask

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic word_t model_alu(input alu_op_e op, input word_t a, input word_t b);
        word_t r;
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a + ~b + 1;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SLL:  r = a << b[4:0];
            OP_SRL:  r = a >> b[4:0];
            OP_SRA:  r = word_t'($signed(a) >>> b[4:0]);
            OP_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            OP_LUI:  r = b;
            default: r = 'x;
        endcase
        return r;
    endfunction

    task automatic check_idle(input string name);
        assert (!res_valid_o) else report_mismatch({name, "_res_valid"}, 0, res_valid_o);
        assert (iq_ready_o) else report_mismatch({name, "_iq_ready"}, 1, iq_ready_o);
    endtask

    // a result handed over on the coming edge
    task automatic check_result();
        int    rob;
        word_t exp;
        if (res_valid_o && res_ready_i) begin
            rob = int'(res_o.rob_id);
            assert (m_pending[rob])
                else report_failure("result carries a rob tag that is not outstanding");
            assert (m_known[rob][0] && m_known[rob][1])
                else report_failure("result left before its source tag was broadcast");
            exp = model_alu(m_op[rob], m_src[rob][0], m_src[rob][1]);
            assert (res_o.w_data == exp) else report_mismatch("result_data", exp, res_o.w_data);
            assert (res_o.w_reg == m_wreg[rob])
                else report_mismatch("result_w_reg", m_wreg[rob], res_o.w_reg);
            m_pending[rob] = 1'b0;
            n_outstanding--;
        end
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    task automatic drive_cdb();
        int idx;
        int tag;
        for (int p = 0; p < `CDB_CNT; p++) begin
            cdb_i[p] = '0;
            if (wake_q.size() > 0 && rand_below(3) == 0) begin
                idx = int'(rand_below(wake_q.size()));
                tag = wake_q[idx];
                wake_q.delete(idx);
                cdb_i[p].valid  = 1'b1;
                cdb_i[p].rob_id = rob_id_t'(tag);
                cdb_i[p].data   = $random(seed);
                m_src[wake_rob[tag]][wake_src[tag]]   = cdb_i[p].data;
                m_known[wake_rob[tag]][wake_src[tag]] = 1'b1;
                tag_busy[tag] = 1'b0;
            end
        end
    endtask

    task automatic dispatch_one(input bit all_valid);
        alu_inst_t inst;
        int        rob;
        int        tag;
        while (m_pending[next_rob]) begin
            next_rob = (next_rob + 1) % NTAG;
        end
        rob         = next_rob;
        next_rob    = (next_rob + 1) % NTAG;
        inst        = '0;
        inst.op     = alu_op_e'(4'(rand_below(11)));
        inst.rob_id = rob_id_t'(rob);
        inst.w_reg  = (rand_below(4) != 0);
        for (int s = 0; s < 2; s++) begin
            inst.src_data[s] = $random(seed);
            if (all_valid || wake_q.size() >= 6 || rand_below(2) == 0) begin
                inst.src_valid[s] = 1'b1;
                m_known[rob][s]   = 1'b1;
            end else begin
                // fresh wake tag, one waiter per tag
                while (tag_busy[next_wake]) begin
                    next_wake = (next_wake + 1) % NTAG;
                end
                tag             = next_wake;
                next_wake       = (next_wake + 1) % NTAG;
                tag_busy[tag]   = 1'b1;
                wake_rob[tag]   = rob;
                wake_src[tag]   = s;
                wake_q.push_back(tag);
                inst.src_tag[s] = rob_id_t'(tag);
                m_known[rob][s] = 1'b0;
            end
            m_src[rob][s] = inst.src_data[s];
        end
        m_op[rob]      = inst.op;
        m_wreg[rob]    = inst.w_reg;
        m_pending[rob] = 1'b1;
        n_outstanding++;
        n_sent++;
        disp_i       = inst;
        disp_valid_i = 1'b1;
    endtask

    task automatic cycle(input bit disp_en, input bit all_valid, input int rdy_pct);
        @(negedge clk);
        res_ready_i = (int'(rand_below(100)) < rdy_pct);
        check_result();
        drive_cdb();
        disp_valid_i = 1'b0;
        if (disp_en && iq_ready_o) begin
            dispatch_one(all_valid);
        end
    endtask

    task automatic flush_all();
        @(negedge clk);
        flush_i      = 1'b1;
        res_ready_i  = 1'b0;
        disp_valid_i = 1'b0;
        cdb_i        = '0;
        for (int t = 0; t < NTAG; t++) begin
            m_pending[t] = 1'b0;
            tag_busy[t]  = 1'b0;
        end
        wake_q.delete();
        n_outstanding = 0;
        @(negedge clk);
        flush_i = 1'b0;
        check_idle("after_flush");
    endtask

    task automatic drain();
        while (n_outstanding != 0) begin
            cycle(1'b0, 1'b0, 100);
        end
    endtask

    // consumer alternates between fast and slow stretches
    task automatic random_phase(input int count);
        int start;
        int pct;
        start = n_sent;
        while (n_sent - start < count) begin
            pct = (((n_sent / 25) % 2) != 0) ? 20 : 90;
            cycle(rand_below(10) < 7, 1'b0, pct);
        end
    endtask

    initial begin
        int lat;
        clk           = 1'b0;
        rst_i         = 1'b1;
        flush_i       = 1'b0;
        disp_i        = '0;
        disp_valid_i  = 1'b0;
        cdb_i         = '0;
        res_ready_i   = 1'b0;
        cycle_cnt     = 0;
        n_sent        = 0;
        n_outstanding = 0;
        next_rob      = 0;
        next_wake     = 0;
        for (int t = 0; t < NTAG; t++) begin
            m_pending[t] = 1'b0;
            tag_busy[t]  = 1'b0;
        end
        repeat (16) @(negedge clk);
        rst_i = 1'b0;
        @(negedge clk);
        check_idle("after_reset");

        // lone instruction through an empty queue
        cycle(1'b1, 1'b1, 100);
        lat = 0;
        while (!res_valid_o && lat < 20) begin
            cycle(1'b0, 1'b0, 100);
            lat++;
        end
        assert (lat == 4) else report_mismatch("dispatch_to_result_latency", 4, lat);
        drain();

        // consumer blocked, everything backs up into the queue
        repeat (24) cycle(1'b1, 1'b1, 0);
        assert (!iq_ready_o)
            else report_failure("iq_ready_o stayed high with every entry occupied");
        drain();

        repeat (8) cycle(1'b1, 1'b0, 50);
        flush_all();

        random_phase(N_RAND / 2);
        flush_all();
        random_phase(N_RAND / 2);
        drain();

        repeat (8) cycle(1'b0, 1'b0, 100);
        assert (!res_valid_o) else report_failure("extra result after all instructions returned");
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== alu_issue_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "alu_issue_defines.svh"

module alu_issue_top (
    input  wire                                            clk,
    input  wire                                            rst_i,
    input  wire                                            flush_i,
    input  wire  alu_op_pkg::alu_inst_t                    disp_i,
    input  wire                                            disp_valid_i,
    output logic                                           iq_ready_o,
    input  wire  core_types_pkg::cdb_beat_t [`CDB_CNT-1:0] cdb_i,
    output core_types_pkg::alu_result_t                    res_o,
    output logic                                           res_valid_o,
    input  wire                                            res_ready_i
);
    import core_types_pkg::*;

    alu_result_t iq_res;
    logic        iq_res_valid;
    logic        fifo_ready;

    // issue queue and execute
    alu_iq u_iq (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .disp_i       (disp_i),
        .disp_valid_i (disp_valid_i),
        .iq_ready_o   (iq_ready_o),
        .cdb_i        (cdb_i),
        .fifo_ready_i (fifo_ready),
        .res_o        (iq_res),
        .res_valid_o  (iq_res_valid)
    );

    // results toward the consumer
    result_fifo u_fifo (
        .clk     (clk),
        .rst_i   (rst_i),
        .flush_i (flush_i),
        .push_i  (iq_res_valid),
        .data_i  (iq_res),
        .ready_o (fifo_ready),
        .data_o  (res_o),
        .valid_o (res_valid_o),
        .pop_i   (res_ready_i)
    );

endmodule

`default_nettype wire

// ==== alu_op_pkg.sv ====
`default_nettype none

package alu_op_pkg;

    // ----------------------------------------
    // integer alu opcodes
    // ----------------------------------------
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SRA  = 4'd7,
        OP_SLT  = 4'd8,
        OP_SLTU = 4'd9,
        // passes operand b through
        OP_LUI  = 4'd10
    } alu_op_e;

    // dispatched instruction, index 0 is operand a
    typedef struct packed {
        alu_op_e                            op;
        core_types_pkg::rob_id_t            rob_id;
        logic                               w_reg;
        core_types_pkg::rob_id_t [1:0]      src_tag;
        logic [1:0]                         src_valid;
        core_types_pkg::word_t [1:0]        src_data;
    } alu_inst_t;

endpackage

`default_nettype wire

// ==== core_types_pkg.sv ====
`default_nettype none

`include "alu_issue_defines.svh"

package core_types_pkg;

    // machine word and rob tag
    typedef logic [`ALU_XLEN-1:0] word_t;
    typedef logic [`ROB_ID_W-1:0] rob_id_t;

    // ----------------------------------------
    // one beat on a common data bus port
    // ----------------------------------------
    typedef struct packed {
        logic    valid;
        rob_id_t rob_id;
        word_t   data;
    } cdb_beat_t;

    // finished alu result toward the consumer
    typedef struct packed {
        rob_id_t rob_id;
        // set when the result writes a register
        logic    w_reg;
        word_t   w_data;
    } alu_result_t;

endpackage

`default_nettype wire

// ==== iq_entry.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "alu_issue_defines.svh"

module iq_entry (
    input  wire                                           clk,
    input  wire                                           rst_i,
    input  wire                                           flush_i,
    input  wire                                           init_i,
    input  wire  alu_op_pkg::alu_inst_t                   inst_i,
    input  wire  core_types_pkg::cdb_beat_t [`CDB_CNT-1:0] cdb_i,
    input  wire                                           select_i,
    output logic                                          ready_o,
    output alu_op_pkg::alu_inst_t                         inst_o
);
    import alu_op_pkg::*;

    logic      occ_q;
    alu_inst_t inst_q;
    alu_inst_t inst_nxt;

    // ----------------------------------------
    // operand capture from the cdb
    // ----------------------------------------
    // a fresh dispatch is also checked, so a tag broadcast on the
    // dispatch edge is not missed
    always_comb begin
        inst_nxt = init_i ? inst_i : inst_q;
        for (int s = 0; s < 2; s++) begin
            for (int p = 0; p < `CDB_CNT; p++) begin
                if (!inst_nxt.src_valid[s] && cdb_i[p].valid &&
                    (cdb_i[p].rob_id == inst_nxt.src_tag[s])) begin
                    inst_nxt.src_data[s]  = cdb_i[p].data;
                    inst_nxt.src_valid[s] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (init_i || occ_q) begin
            inst_q <= inst_nxt;
        end
    end

    // occupied bit
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            occ_q <= 1'b0;
        end else if (init_i) begin
            occ_q <= 1'b1;
        end else if (select_i) begin
            occ_q <= 1'b0;
        end
    end

    assign ready_o = occ_q && (&inst_q.src_valid);
    assign inst_o  = inst_q;

    // the queue only loads free slots and only issues occupied ones
    a_init_select_excl : assert property (
        @(posedge clk) disable iff (rst_i)
        !(init_i && select_i)
    );

endmodule

`default_nettype wire

// ==== result_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "alu_issue_defines.svh"

module result_fifo (
    input  wire                                clk,
    input  wire                                rst_i,
    input  wire                                flush_i,
    input  wire                                push_i,
    input  wire  core_types_pkg::alu_result_t  data_i,
    output logic                               ready_o,
    output core_types_pkg::alu_result_t        data_o,
    output logic                               valid_o,
    input  wire                                pop_i
);
    import core_types_pkg::*;

    localparam int PTR_W = $clog2(`RES_FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    alu_result_t      mem [`RES_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push_fire;
    logic             pop_fire;

    assign ready_o   = (count_q != CNT_W'(`RES_FIFO_DEPTH));
    assign valid_o   = (count_q != '0);
    assign push_fire = push_i && ready_o;
    assign pop_fire  = pop_i && valid_o;
    assign data_o    = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    // pointers wrap on the power of two depth
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + PTR_W'(push_fire);
            rd_ptr_q <= rd_ptr_q + PTR_W'(pop_fire);
            count_q  <= count_q + CNT_W'(push_fire) - CNT_W'(pop_fire);
        end
    end

    // a push refused while full is offered again with the same record
    a_no_push_full : assert property (
        @(posedge clk) disable iff (rst_i || flush_i)
        (push_i && !ready_o) |=> (push_i && $stable(data_i))
    );

endmodule

`default_nettype wire
